// File: design/dmem_bank.sv
`timescale 1ns/1ps
`default_nettype none

module dmem_bank #(
    parameter int BANK_WORDS = 64,
    parameter int NUM_BANKS  = 4
) (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          wb_cyc,
    input  wire                          wb_stb,
    input  wire                          wb_we,
    input  wire [lsu_pkg::XLEN-4:0]      wb_adr,
    input  wire [lsu_pkg::XLEN-1:0]      wb_dat_w,
    input  wire [7:0]                    wb_sel,
    output logic                         wb_ack,
    output logic [lsu_pkg::XLEN-1:0]     wb_dat_r
);
    import lsu_pkg::*;

    localparam int SEL_BITS = $clog2(NUM_BANKS);
    localparam int WORD_W   = $clog2(BANK_WORDS);

    logic [XLEN-1:0]    mem [BANK_WORDS];
    logic [WORD_W-1:0]  word_idx;
    logic               access;

    // Low bits picked this bank, the ones above the bank size wrap
    assign word_idx = wb_adr[SEL_BITS +: WORD_W];

    // A held strobe is served once, the ack cycle blocks a second pass
    assign access = wb_cyc && wb_stb && !wb_ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= access;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            // Unwritten words read back as zero
            for (int w = 0; w < BANK_WORDS; w++) begin
                mem[w] <= '0;
            end
        end else if (access) begin
            wb_dat_r <= mem[word_idx];
            if (wb_we) begin
                for (int i = 0; i < 8; i++) begin
                    if (wb_sel[i]) begin
                        mem[word_idx][i*8 +: 8] <= wb_dat_w[i*8 +: 8];
                    end
                end
            end
        end
    end

    // Master must still hold the request while the ack is out
    a_ack_follows_req: assert property (@(posedge clk) disable iff (rst)
        wb_ack |-> $past(wb_cyc && wb_stb) && wb_cyc && wb_stb);

endmodule

`default_nettype wire

// File: design/lsp_load_align.sv
`timescale 1ns/1ps
`default_nettype none

module lsp_load_align #(
    parameter int NUM_BANKS = 4
) (
    input  wire [NUM_BANKS-1:0]                     wb_ack,
    input  wire [NUM_BANKS-1:0][lsu_pkg::XLEN-1:0]  wb_dat_r,
    input  wire lsu_pkg::mem_width_e                ld_width,
    input  wire                                     ld_unsigned,
    input  wire [2:0]                               ld_offset,
    input  wire [lsu_pkg::REG_ADDR_W-1:0]           ld_dst,
    input  wire [lsu_pkg::XLEN-1:0]                 ld_pc,
    input  wire                                     ld_is_load,
    output logic                                    bus_ack,
    output logic                                    push_valid,
    output logic [lsu_pkg::XLEN-1:0]                push_result,
    output logic [lsu_pkg::REG_ADDR_W-1:0]          push_dst,
    output logic [lsu_pkg::XLEN-1:0]                push_pc
);
    import lsu_pkg::*;

    logic [XLEN-1:0]  rd_data;
    logic [7:0]       rd_byte;
    logic [15:0]      rd_half;
    logic [31:0]      rd_word;

    assign bus_ack = |wb_ack;

    // Only one bank is strobed, so an AND-OR merge is enough
    always_comb begin
        rd_data = '0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (wb_ack[b]) begin
                rd_data = rd_data | wb_dat_r[b];
            end
        end
    end

    // Lane pick, the offset is already known to be aligned
    assign rd_byte = rd_data[{ld_offset, 3'b000} +: 8];
    assign rd_half = rd_data[{ld_offset[2:1], 4'b0000} +: 16];
    assign rd_word = rd_data[{ld_offset[2], 5'b00000} +: 32];

    always_comb begin
        case (ld_width)
            MW_BYTE: begin
                push_result = {{(XLEN-8){rd_byte[7] && !ld_unsigned}}, rd_byte};
            end
            MW_HALF: begin
                push_result = {{(XLEN-16){rd_half[15] && !ld_unsigned}}, rd_half};
            end
            MW_WORD: begin
                push_result = {{(XLEN-32){rd_word[31] && !ld_unsigned}}, rd_word};
            end
            default: begin
                push_result = rd_data;
            end
        endcase
    end

    // Store acks end the bus cycle but queue nothing
    assign push_valid = bus_ack && ld_is_load;
    assign push_dst   = ld_dst;
    assign push_pc    = ld_pc;

    always_comb begin
        a_one_ack: assert ($onehot0(wb_ack));
    end

endmodule

`default_nettype wire

// File: design/lsp_request.sv
`timescale 1ns/1ps
`default_nettype none

module lsp_request #(
    parameter int NUM_BANKS = 4
) (
    input  wire                               clk,
    input  wire                               rst,
    input  wire                               ix_valid,
    input  wire lsu_pkg::mem_op_e             ix_op,
    input  wire lsu_pkg::mem_width_e          ix_width,
    input  wire                               ix_unsigned,
    input  wire [lsu_pkg::XLEN-1:0]           ix_base,
    input  wire [11:0]                        ix_offset,
    input  wire [lsu_pkg::XLEN-1:0]           ix_source,
    input  wire [lsu_pkg::REG_ADDR_W-1:0]     ix_dst,
    input  wire [lsu_pkg::XLEN-1:0]           ix_pc,
    input  wire                               fifo_ready,
    input  wire                               bus_ack,
    output logic                              ix_ready,
    output logic                              misaligned_load,
    output logic                              misaligned_store,
    output logic [lsu_pkg::XLEN-1:0]          fault_pc,
    output logic                              wb_cyc,
    output logic [NUM_BANKS-1:0]              wb_stb,
    output logic                              wb_we,
    output logic [lsu_pkg::XLEN-4:0]          wb_adr,
    output logic [lsu_pkg::XLEN-1:0]          wb_dat_w,
    output logic [7:0]                        wb_sel,
    output lsu_pkg::mem_width_e               ld_width,
    output logic                              ld_unsigned,
    output logic [2:0]                        ld_offset,
    output logic [lsu_pkg::REG_ADDR_W-1:0]    ld_dst,
    output logic [lsu_pkg::XLEN-1:0]          ld_pc,
    output logic                              ld_is_load
);
    import lsu_pkg::*;

    localparam int SEL_W = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;

    req_state_e             state;
    logic                   issue_en;
    logic [XLEN-1:0]        agu_addr;
    logic                   misaligned;
    logic                   issue;
    logic                   start;
    logic [XLEN-1:0]        st_data;
    logic [7:0]             st_mask;
    logic [SEL_W-1:0]       bank_idx;
    logic [NUM_BANKS-1:0]   stb_dec;

    // Address generation with the 12-bit signed displacement
    assign agu_addr = ix_base + {{(XLEN-12){ix_offset[11]}}, ix_offset};

    // Natural alignment only
    always_comb begin
        case (ix_width)
            MW_HALF:   misaligned = agu_addr[0];
            MW_WORD:   misaligned = |agu_addr[1:0];
            MW_DOUBLE: misaligned = |agu_addr[2:0];
            default:   misaligned = 1'b0;
        endcase
    end

    // Store data is copied to every lane so the mask alone picks the bytes
    always_comb begin
        case (ix_width)
            MW_BYTE: begin
                st_data = {8{ix_source[7:0]}};
                st_mask = 8'h01 << agu_addr[2:0];
            end
            MW_HALF: begin
                st_data = {4{ix_source[15:0]}};
                st_mask = 8'h03 << agu_addr[2:0];
            end
            MW_WORD: begin
                st_data = {2{ix_source[31:0]}};
                st_mask = 8'h0f << agu_addr[2:0];
            end
            default: begin
                st_data = ix_source;
                st_mask = 8'hff;
            end
        endcase
    end

    // Doublewords are interleaved across the banks
    assign bank_idx = agu_addr[SEL_W+2:3] & SEL_W'(NUM_BANKS - 1);

    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            stb_dec[b] = (bank_idx == SEL_W'(b));
        end
    end

    assign ix_ready = issue_en && (state == REQ_IDLE) && fifo_ready;
    assign issue    = ix_valid && ix_ready;
    assign start    = issue && !misaligned;

    always_ff @(posedge clk) begin
        if (rst) begin
            state            <= REQ_IDLE;
            issue_en         <= 1'b0;
            wb_cyc           <= 1'b0;
            wb_stb           <= '0;
            misaligned_load  <= 1'b0;
            misaligned_store <= 1'b0;
        end else begin
            issue_en         <= 1'b1;
            misaligned_load  <= issue && misaligned && (ix_op == MEM_LOAD);
            misaligned_store <= issue && misaligned && (ix_op == MEM_STORE);
            case (state)
                REQ_IDLE: begin
                    if (start) begin
                        state  <= REQ_BUS;
                        wb_cyc <= 1'b1;
                        wb_stb <= stb_dec;
                    end
                end
                REQ_BUS: begin
                    // Classic cycle ends on the edge that samples ack
                    if (bus_ack) begin
                        state  <= REQ_IDLE;
                        wb_cyc <= 1'b0;
                        wb_stb <= '0;
                    end
                end
                default: state <= REQ_IDLE;
            endcase
        end
    end

    // Request fields and load metadata, held for the whole cycle
    always_ff @(posedge clk) begin
        if (start) begin
            wb_we       <= (ix_op == MEM_STORE);
            wb_adr      <= agu_addr[XLEN-1:3];
            wb_dat_w    <= st_data;
            wb_sel      <= st_mask;
            ld_width    <= ix_width;
            ld_unsigned <= ix_unsigned;
            ld_offset   <= agu_addr[2:0];
            ld_dst      <= ix_dst;
            ld_pc       <= ix_pc;
            ld_is_load  <= (ix_op == MEM_LOAD);
        end
        if (issue && misaligned) begin
            fault_pc <= ix_pc;
        end
    end

    // Strobe and request fields stay put until the bank answers
    a_req_held: assert property (@(posedge clk) disable iff (rst)
        wb_cyc && !bus_ack |=> wb_cyc && $stable(wb_stb) && $stable(wb_adr)
            && $stable(wb_sel) && $stable(wb_we));

endmodule

`default_nettype wire

// File: design/lsp_result_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module lsp_result_fifo (
    input  wire                              clk,
    input  wire                              rst,
    input  wire                              push_valid,
    input  wire [lsu_pkg::XLEN-1:0]          push_result,
    input  wire [lsu_pkg::REG_ADDR_W-1:0]    push_dst,
    input  wire [lsu_pkg::XLEN-1:0]          push_pc,
    input  wire                              wb_ready,
    output logic                             fifo_ready,
    output logic                             wb_valid,
    output logic [lsu_pkg::XLEN-1:0]         wb_result,
    output logic [lsu_pkg::REG_ADDR_W-1:0]   wb_dst,
    output logic [lsu_pkg::XLEN-1:0]         wb_pc
);
    import lsu_pkg::*;

    logic [XLEN-1:0]        res_q [2];
    logic [REG_ADDR_W-1:0]  dst_q [2];
    logic [XLEN-1:0]        pc_q  [2];
    logic                   wr_ptr;
    logic                   rd_ptr;
    logic [1:0]             count;
    logic                   pop;

    assign fifo_ready = (count != 2'd2);
    assign wb_valid   = (count != 2'd0);
    assign pop        = wb_valid && wb_ready;

    // Head entry is on the outputs without a read strobe
    assign wb_result = res_q[rd_ptr];
    assign wb_dst    = dst_q[rd_ptr];
    assign wb_pc     = pc_q[rd_ptr];

    always_ff @(posedge clk) begin
        if (push_valid) begin
            res_q[wr_ptr] <= push_result;
            dst_q[wr_ptr] <= push_dst;
            pc_q[wr_ptr]  <= push_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push_valid) begin
                wr_ptr <= !wr_ptr;
            end
            if (pop) begin
                rd_ptr <= !rd_ptr;
            end
            case ({push_valid, pop})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;
            endcase
        end
    end

    // Issue is held off while full, so a load in flight always has room
    a_no_push_full: assert property (@(posedge clk) disable iff (rst)
        push_valid |-> fifo_ready);

endmodule

`default_nettype wire

// File: design/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    // Data and address width of the core
    localparam int XLEN = 64;

    // Register file index width
    localparam int REG_ADDR_W = 5;

    // Kind of memory access presented by issue
    typedef enum logic {
        MEM_LOAD  = 1'b0,
        MEM_STORE = 1'b1
    } mem_op_e;

    // Access size, encoded as log2 of the byte count
    typedef enum logic [1:0] {
        MW_BYTE   = 2'd0,
        MW_HALF   = 2'd1,
        MW_WORD   = 2'd2,
        MW_DOUBLE = 2'd3
    } mem_width_e;

    // Request stage, either waiting for issue or holding a bus cycle
    typedef enum logic {
        REQ_IDLE = 1'b0,
        REQ_BUS  = 1'b1
    } req_state_e;

endpackage

`default_nettype wire

// File: design/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top #(
    parameter int NUM_BANKS  = 4,
    parameter int BANK_WORDS = 64
) (
    input  wire                              clk,
    input  wire                              rst,
    input  wire                              ix_valid,
    input  wire lsu_pkg::mem_op_e            ix_op,
    input  wire lsu_pkg::mem_width_e         ix_width,
    input  wire                              ix_unsigned,
    input  wire [lsu_pkg::XLEN-1:0]          ix_base,
    input  wire [11:0]                       ix_offset,
    input  wire [lsu_pkg::XLEN-1:0]          ix_source,
    input  wire [lsu_pkg::REG_ADDR_W-1:0]    ix_dst,
    input  wire [lsu_pkg::XLEN-1:0]          ix_pc,
    output logic                             ix_ready,
    output logic                             wb_valid,
    output logic [lsu_pkg::XLEN-1:0]         wb_result,
    output logic [lsu_pkg::REG_ADDR_W-1:0]   wb_dst,
    output logic [lsu_pkg::XLEN-1:0]         wb_pc,
    input  wire                              wb_ready,
    output logic                             misaligned_load,
    output logic                             misaligned_store,
    output logic [lsu_pkg::XLEN-1:0]         fault_pc
);
    import lsu_pkg::*;

    // Shared Wishbone request side
    logic                              wb_cyc;
    logic [NUM_BANKS-1:0]              wb_stb;
    logic                              wb_we;
    logic [XLEN-4:0]                   wb_adr;
    logic [XLEN-1:0]                   wb_dat_w;
    logic [7:0]                        wb_sel;
    // One response per bank
    logic [NUM_BANKS-1:0]              wb_ack;
    logic [NUM_BANKS-1:0][XLEN-1:0]    wb_dat_r;
    logic                              bus_ack;

    mem_width_e                        ld_width;
    logic                              ld_unsigned;
    logic [2:0]                        ld_offset;
    logic [REG_ADDR_W-1:0]             ld_dst;
    logic [XLEN-1:0]                   ld_pc;
    logic                              ld_is_load;

    logic                              push_valid;
    logic [XLEN-1:0]                   push_result;
    logic [REG_ADDR_W-1:0]             push_dst;
    logic [XLEN-1:0]                   push_pc;
    logic                              fifo_ready;

    lsp_request #(
        .NUM_BANKS (NUM_BANKS)
    ) lsp_request_i (
        .clk              (clk),
        .rst              (rst),
        .ix_valid         (ix_valid),
        .ix_op            (ix_op),
        .ix_width         (ix_width),
        .ix_unsigned      (ix_unsigned),
        .ix_base          (ix_base),
        .ix_offset        (ix_offset),
        .ix_source        (ix_source),
        .ix_dst           (ix_dst),
        .ix_pc            (ix_pc),
        .fifo_ready       (fifo_ready),
        .bus_ack          (bus_ack),
        .ix_ready         (ix_ready),
        .misaligned_load  (misaligned_load),
        .misaligned_store (misaligned_store),
        .fault_pc         (fault_pc),
        .wb_cyc           (wb_cyc),
        .wb_stb           (wb_stb),
        .wb_we            (wb_we),
        .wb_adr           (wb_adr),
        .wb_dat_w         (wb_dat_w),
        .wb_sel           (wb_sel),
        .ld_width         (ld_width),
        .ld_unsigned      (ld_unsigned),
        .ld_offset        (ld_offset),
        .ld_dst           (ld_dst),
        .ld_pc            (ld_pc),
        .ld_is_load       (ld_is_load)
    );

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        dmem_bank #(
            .BANK_WORDS (BANK_WORDS),
            .NUM_BANKS  (NUM_BANKS)
        ) dmem_bank_i (
            .clk      (clk),
            .rst      (rst),
            .wb_cyc   (wb_cyc),
            .wb_stb   (wb_stb[b]),
            .wb_we    (wb_we),
            .wb_adr   (wb_adr),
            .wb_dat_w (wb_dat_w),
            .wb_sel   (wb_sel),
            .wb_ack   (wb_ack[b]),
            .wb_dat_r (wb_dat_r[b])
        );
    end

    lsp_load_align #(
        .NUM_BANKS (NUM_BANKS)
    ) lsp_load_align_i (
        .wb_ack      (wb_ack),
        .wb_dat_r    (wb_dat_r),
        .ld_width    (ld_width),
        .ld_unsigned (ld_unsigned),
        .ld_offset   (ld_offset),
        .ld_dst      (ld_dst),
        .ld_pc       (ld_pc),
        .ld_is_load  (ld_is_load),
        .bus_ack     (bus_ack),
        .push_valid  (push_valid),
        .push_result (push_result),
        .push_dst    (push_dst),
        .push_pc     (push_pc)
    );

    lsp_result_fifo lsp_result_fifo_i (
        .clk         (clk),
        .rst         (rst),
        .push_valid  (push_valid),
        .push_result (push_result),
        .push_dst    (push_dst),
        .push_pc     (push_pc),
        .wb_ready    (wb_ready),
        .fifo_ready  (fifo_ready),
        .wb_valid    (wb_valid),
        .wb_result   (wb_result),
        .wb_dst      (wb_dst),
        .wb_pc       (wb_pc)
    );

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log
rm -f sim.log
{ verilator --binary --timing --assert --top-module tb_lsu -f sources.f -o sim_lsu \
    && ./obj_dir/sim_lsu; } > sim.log 2>&1 || echo "Regression failed" >> sim.log
cat sim.log
grep -q "Regression failed" sim.log && exit 1 || exit 0

// File: sources.f
design/lsu_pkg.sv
design/lsp_request.sv
design/dmem_bank.sv
design/lsp_load_align.sv
design/lsp_result_fifo.sv
design/lsu_top.sv
test/tb_lsu.sv

// File: test/tb_lsu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lsu;
    import lsu_pkg::*;

    localparam int NUM_BANKS      = 4;
    localparam int BANK_WORDS     = 64;
    localparam int MEM_BYTES      = NUM_BANKS * BANK_WORDS * 8;
    localparam int MEM_AW         = $clog2(MEM_BYTES);
    localparam int NUM_OPS        = 1500;
    localparam int TIMEOUT_CYCLES = NUM_OPS * 12 + 100;

    logic                   clk;
    logic                   rst;
    logic                   ix_valid;
    mem_op_e                ix_op;
    mem_width_e             ix_width;
    logic                   ix_unsigned;
    logic [XLEN-1:0]        ix_base;
    logic [11:0]            ix_offset;
    logic [XLEN-1:0]        ix_source;
    logic [REG_ADDR_W-1:0]  ix_dst;
    logic [XLEN-1:0]        ix_pc;
    logic                   ix_ready;
    logic                   wb_valid;
    logic [XLEN-1:0]        wb_result;
    logic [REG_ADDR_W-1:0]  wb_dst;
    logic [XLEN-1:0]        wb_pc;
    logic                   wb_ready;
    logic                   misaligned_load;
    logic                   misaligned_store;
    logic [XLEN-1:0]        fault_pc;

    // Reference model, memory bytes and the loads still owed to writeback
    logic [7:0]             mem_model [MEM_BYTES];
    logic [XLEN-1:0]        exp_result [$];
    logic [REG_ADDR_W-1:0]  exp_dst [$];
    logic [XLEN-1:0]        exp_pc [$];
    logic                   fault_pending;
    mem_op_e                fault_op;
    logic [XLEN-1:0]        fault_pc_exp;
    logic [31:0]            lcg_state;
    int                     issued;
    int                     stall_cycles;
    int                     busy_cycles;
    logic                   load_in_flight;
    int                     error_count;
    int                     cycle_count;

    lsu_top #(
        .NUM_BANKS  (NUM_BANKS),
        .BANK_WORDS (BANK_WORDS)
    ) lsu_top_i (
        .clk              (clk),
        .rst              (rst),
        .ix_valid         (ix_valid),
        .ix_op            (ix_op),
        .ix_width         (ix_width),
        .ix_unsigned      (ix_unsigned),
        .ix_base          (ix_base),
        .ix_offset        (ix_offset),
        .ix_source        (ix_source),
        .ix_dst           (ix_dst),
        .ix_pc            (ix_pc),
        .ix_ready         (ix_ready),
        .wb_valid         (wb_valid),
        .wb_result        (wb_result),
        .wb_dst           (wb_dst),
        .wb_pc            (wb_pc),
        .wb_ready         (wb_ready),
        .misaligned_load  (misaligned_load),
        .misaligned_store (misaligned_store),
        .fault_pc         (fault_pc)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state ^ (lcg_state >> 15);
    endfunction

    function automatic logic is_misaligned(input logic [XLEN-1:0] addr, input mem_width_e width);
        int unsigned bytes;
        bytes = 1 << width;
        return (addr & XLEN'(bytes - 1)) != '0;
    endfunction

    // Little-endian placement, byte i of the data lands at addr + i
    function automatic void model_store(input logic [XLEN-1:0] addr, input mem_width_e width,
                                        input logic [XLEN-1:0] data);
        int unsigned       bytes;
        logic [MEM_AW-1:0] idx;
        bytes = 1 << width;
        for (int i = 0; i < int'(bytes); i++) begin
            idx = MEM_AW'(addr + XLEN'(i));
            mem_model[idx] = data[8*i +: 8];
        end
    endfunction

    function automatic logic [XLEN-1:0] model_load(input logic [XLEN-1:0] addr,
                                                   input mem_width_e width, input logic uns);
        int unsigned       bytes;
        logic [MEM_AW-1:0] idx;
        logic [XLEN-1:0]   value;
        bytes = 1 << width;
        value = '0;
        for (int i = 0; i < int'(bytes); i++) begin
            idx = MEM_AW'(addr + XLEN'(i));
            value[8*i +: 8] = mem_model[idx];
        end
        // Sign sits in the top bit of the last byte read
        if (!uns && bytes < 8 && value[8*bytes-1]) begin
            value |= ~((XLEN'(1) << (8*bytes)) - XLEN'(1));
        end
        return value;
    endfunction

    task automatic stop_on_error(input string msg);
        error_count++;
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_load(input logic [XLEN-1:0] exp_res, input logic [REG_ADDR_W-1:0] exp_d,
                              input logic [XLEN-1:0] exp_p);
        if (wb_result !== exp_res) begin
            stop_on_error($sformatf("[ERROR] wb_result: expected 0x%h, got 0x%h (pc 0x%h)",
                                    exp_res, wb_result, exp_p));
        end
        if (wb_dst !== exp_d) begin
            stop_on_error($sformatf("[ERROR] wb_dst: expected 0x%h, got 0x%h", exp_d, wb_dst));
        end
        if (wb_pc !== exp_p) begin
            stop_on_error($sformatf("[ERROR] wb_pc: expected 0x%h, got 0x%h", exp_p, wb_pc));
        end
    endtask

    task automatic check_fault(input mem_op_e exp_op, input logic [XLEN-1:0] exp_p);
        if (misaligned_load !== (exp_op == MEM_LOAD)) begin
            stop_on_error($sformatf("[ERROR] misaligned_load: expected 0x%h, got 0x%h",
                                    exp_op == MEM_LOAD, misaligned_load));
        end
        if (misaligned_store !== (exp_op == MEM_STORE)) begin
            stop_on_error($sformatf("[ERROR] misaligned_store: expected 0x%h, got 0x%h",
                                    exp_op == MEM_STORE, misaligned_store));
        end
        if (fault_pc !== exp_p) begin
            stop_on_error($sformatf("[ERROR] fault_pc: expected 0x%h, got 0x%h", exp_p, fault_pc));
        end
    endtask

    task automatic check_flow(input logic exp_rdy, input logic exp_vld);
        if (ix_ready !== exp_rdy) begin
            stop_on_error($sformatf("[ERROR] ix_ready: expected 0x%h, got 0x%h",
                                    exp_rdy, ix_ready));
        end
        if (wb_valid !== exp_vld) begin
            stop_on_error($sformatf("[ERROR] wb_valid: expected 0x%h, got 0x%h",
                                    exp_vld, wb_valid));
        end
    endtask

    task automatic drive_random_op();
        logic [31:0]     r_ctl;
        logic [31:0]     r_adr;
        logic [31:0]     r_hi;
        logic [31:0]     r_lo;
        logic [XLEN-1:0] addr;
        int unsigned     bytes;
        r_ctl = next_random();
        r_adr = next_random();
        r_hi  = next_random();
        r_lo  = next_random();
        ix_op       = r_ctl[31] ? MEM_STORE : MEM_LOAD;
        ix_width    = mem_width_e'(r_ctl[30:29]);
        ix_unsigned = r_ctl[28];
        ix_dst      = r_ctl[27:23];
        ix_pc       = 64'h8000_0000 + XLEN'(issued) * XLEN'(4);
        ix_source   = {r_hi, r_lo};
        // Small aligned base, sometimes lifted past the memory size so it wraps
        ix_base = XLEN'(r_adr[31:25]) << 3;
        if (r_adr[24]) begin
            ix_base += XLEN'(r_adr[23:22]) * XLEN'(MEM_BYTES);
        end
        ix_offset = r_adr[21] ? {6'b0, r_adr[20:15]} : r_adr[20:9];
        bytes = 1 << ix_width;
        // One access in eight keeps its raw offset
        if (r_ctl[22:20] != 3'd0) begin
            ix_offset &= ~12'(bytes - 1);
        end
        addr = ix_base + XLEN'($signed(ix_offset));
        if (is_misaligned(addr, ix_width)) begin
            fault_pending = 1'b1;
            fault_op      = ix_op;
            fault_pc_exp  = ix_pc;
        end else if (ix_op == MEM_STORE) begin
            model_store(addr, ix_width, ix_source);
            busy_cycles = 2;
        end else begin
            exp_result.push_back(model_load(addr, ix_width, ix_unsigned));
            exp_dst.push_back(ix_dst);
            exp_pc.push_back(ix_pc);
            // The bus cycle keeps issue closed for two cycles
            busy_cycles    = 2;
            load_in_flight = 1'b1;
        end
        ix_valid = 1'b1;
        issued++;
    endtask

    // Called just after a falling edge, all DUT outputs are stable here
    task automatic run_cycle(input logic allow_issue);
        logic [31:0] r;
        logic        rdy;
        int          held;
        r = next_random();
        // Entries in the result buffer exclude a load still on the bus
        held = exp_result.size() - int'(load_in_flight);
        check_flow((busy_cycles == 0) && (held < 2), held > 0);
        if (busy_cycles > 0) begin
            busy_cycles--;
            if (busy_cycles == 0) begin
                load_in_flight = 1'b0;
            end
        end
        if (fault_pending) begin
            check_fault(fault_op, fault_pc_exp);
            fault_pending = 1'b0;
        end else if (misaligned_load || misaligned_store) begin
            stop_on_error($sformatf("Exception pulse in cycle %0d with no misaligned issue",
                                    cycle_count));
        end
        // Now and then a long stall fills the buffer
        if (stall_cycles == 0 && r[31:28] == 4'd0) begin
            stall_cycles = 8 + int'(r[27:25]);
        end
        if (stall_cycles > 0) begin
            stall_cycles--;
            rdy = 1'b0;
        end else begin
            rdy = r[24] | r[23];
        end
        wb_ready = rdy;
        if (wb_valid && rdy) begin
            check_load(exp_result.pop_front(), exp_dst.pop_front(), exp_pc.pop_front());
        end
        ix_valid = 1'b0;
        if (allow_issue && ix_ready && r[22:21] != 2'd0) begin
            drive_random_op();
        end
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, %0d of %0d operations issued, %0d loads pending",
                 cycle_count, issued, NUM_OPS, exp_result.size());
        $display("Regression failed");
        $fatal(1, "Timeout");
    end

    initial begin
        lcg_state      = 32'ha81e7a93;
        rst            = 1'b1;
        ix_valid       = 1'b0;
        ix_op          = MEM_LOAD;
        ix_width       = MW_BYTE;
        ix_unsigned    = 1'b0;
        ix_base        = '0;
        ix_offset      = '0;
        ix_source      = '0;
        ix_dst         = '0;
        ix_pc          = '0;
        wb_ready       = 1'b0;
        fault_pending  = 1'b0;
        fault_op       = MEM_LOAD;
        fault_pc_exp   = '0;
        issued         = 0;
        stall_cycles   = 0;
        busy_cycles    = 0;
        load_in_flight = 1'b0;
        error_count    = 0;
        for (int i = 0; i < MEM_BYTES; i++) begin
            mem_model[i] = 8'h00;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        while (issued < NUM_OPS || exp_result.size() != 0) begin
            @(negedge clk);
            run_cycle(issued < NUM_OPS);
        end
        // Drain, no stray results or pulses may follow
        repeat (6) begin
            @(negedge clk);
            run_cycle(1'b0);
        end
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
